/* logic/gpu_pkg.sv */
// SIMT core shared definitions
`default_nettype none

package gpu_pkg;

    // Datapath and instruction widths
    localparam int data_width = 8;
    localparam int instr_width = 16;
    localparam int pc_width = 8;
    localparam int prog_depth = 256;

    // Register file shape with the top two entries read-only
    localparam int num_regs = 16;
    localparam int reg_addr_width = 4;
    localparam int reg_thread_count = 14;
    localparam int reg_thread_idx = 15;

    // The thread count needs one bit more than a lane index to reach four
    localparam int max_threads = 4;
    localparam int thread_count_width = 3;
    localparam int lane_idx_width = $clog2(max_threads);

    // Core states in a dense encoding that leaves codes 6 and 7 unused
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        FETCH   = 3'd1,
        DECODE  = 3'd2,
        EXECUTE = 3'd3,
        UPDATE  = 3'd4,
        DONE    = 3'd5
    } core_state_t;

    // Opcodes in instruction bits 15 to 12
    typedef enum logic [3:0] {
        NOP   = 4'b0000,
        BRNZP = 4'b0001,
        CMP   = 4'b0010,
        ADD   = 4'b0011,
        SUB   = 4'b0100,
        MUL   = 4'b0101,
        DIV   = 4'b0110,
        CONST = 4'b1001,
        RET   = 4'b1111
    } opcode_t;

    // ALU arithmetic select
    localparam logic [1:0] alu_add = 2'b00;
    localparam logic [1:0] alu_sub = 2'b01;
    localparam logic [1:0] alu_mul = 2'b10;
    localparam logic [1:0] alu_div = 2'b11;

    // ALU output select
    localparam logic alu_out_arith = 1'b0;
    localparam logic alu_out_cmp = 1'b1;

    // Register write source
    localparam logic reg_in_alu = 1'b0;
    localparam logic reg_in_imm = 1'b1;

endpackage

`default_nettype wire

/* logic/alu.sv */
// Per-thread ALU
`default_nettype none
`timescale 1ns/1ns

module alu import gpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable,
    input  core_state_t           core_state,
    input  logic [1:0]            alu_arith_mux,
    input  logic                  alu_output_mux,
    input  logic [data_width-1:0] rs,
    input  logic [data_width-1:0] rt,
    output logic [data_width-1:0] alu_out
);

    // Difference read as two's complement for the compare flags
    logic [data_width-1:0] diff;
    logic                  cmp_neg;
    logic                  cmp_zero;
    logic                  cmp_pos;

    assign diff = rs - rt;
    assign cmp_neg = diff[data_width-1];
    assign cmp_zero = (diff == '0);
    // Positive means neither negative nor zero
    assign cmp_pos = ~cmp_neg & ~cmp_zero;

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_out <= '0;
        end else if (enable && core_state == EXECUTE) begin
            if (alu_output_mux == alu_out_cmp) begin
                // Flags sit in the low three bits in NZP order
                alu_out <= {{(data_width-3){1'b0}}, cmp_pos, cmp_zero, cmp_neg};
            end else begin
                // All results keep only the low byte
                case (alu_arith_mux)
                    alu_add: alu_out <= rs + rt;
                    alu_sub: alu_out <= rs - rt;
                    alu_mul: alu_out <= rs * rt;
                    default: begin
                        // Division by zero saturates to all ones
                        if (rt == '0) begin
                            alu_out <= '1;
                        end else begin
                            alu_out <= rs / rt;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* logic/decoder.sv */
// Instruction decoder
`default_nettype none
`timescale 1ns/1ns

module decoder import gpu_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  core_state_t               core_state,
    input  logic [instr_width-1:0]    instruction,
    output logic [reg_addr_width-1:0] rd,
    output logic [reg_addr_width-1:0] rs_addr,
    output logic [reg_addr_width-1:0] rt_addr,
    output logic [data_width-1:0]     immediate,
    output logic [2:0]                nzp_mask,
    output logic [pc_width-1:0]       branch_target,
    output logic                      reg_write_enable,
    output logic                      reg_input_mux,
    output logic [1:0]                alu_arith_mux,
    output logic                      alu_output_mux,
    output logic                      nzp_write_enable,
    output logic                      pc_mux,
    output logic                      is_ret
);

    opcode_t opcode;

    assign opcode = opcode_t'(instruction[15:12]);

    // Operand fields are latched in DECODE and used from EXECUTE on
    always_ff @(posedge clk) begin
        if (core_state == DECODE) begin
            rd <= instruction[11:8];
            rs_addr <= instruction[7:4];
            rt_addr <= instruction[3:0];
            immediate <= instruction[7:0];
            nzp_mask <= instruction[11:9];
            branch_target <= instruction[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_write_enable <= 1'b0;
            reg_input_mux <= reg_in_alu;
            alu_arith_mux <= alu_add;
            alu_output_mux <= alu_out_arith;
            nzp_write_enable <= 1'b0;
            pc_mux <= 1'b0;
            is_ret <= 1'b0;
        end else if (core_state == DECODE) begin
            // Start from a NOP and switch on what the opcode needs
            reg_write_enable <= 1'b0;
            reg_input_mux <= reg_in_alu;
            alu_arith_mux <= alu_add;
            alu_output_mux <= alu_out_arith;
            nzp_write_enable <= 1'b0;
            pc_mux <= 1'b0;
            is_ret <= 1'b0;
            case (opcode)
                BRNZP: pc_mux <= 1'b1;
                CMP: begin
                    alu_output_mux <= alu_out_cmp;
                    nzp_write_enable <= 1'b1;
                end
                ADD: reg_write_enable <= 1'b1;
                SUB: begin
                    reg_write_enable <= 1'b1;
                    alu_arith_mux <= alu_sub;
                end
                MUL: begin
                    reg_write_enable <= 1'b1;
                    alu_arith_mux <= alu_mul;
                end
                DIV: begin
                    reg_write_enable <= 1'b1;
                    alu_arith_mux <= alu_div;
                end
                CONST: begin
                    reg_write_enable <= 1'b1;
                    reg_input_mux <= reg_in_imm;
                end
                RET: is_ret <= 1'b1;
                // Unknown codes behave like NOP
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/registers.sv */
// Per-thread register file
`default_nettype none
`timescale 1ns/1ns

module registers import gpu_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          enable,
    input  core_state_t                   core_state,
    input  logic [thread_count_width-1:0] thread_count,
    input  logic [lane_idx_width-1:0]     thread_idx,
    input  logic [reg_addr_width-1:0]     rs_addr,
    input  logic [reg_addr_width-1:0]     rt_addr,
    input  logic [reg_addr_width-1:0]     rd,
    input  logic                          reg_write_enable,
    input  logic                          reg_input_mux,
    input  logic [data_width-1:0]         immediate,
    input  logic [data_width-1:0]         alu_out,
    input  logic [reg_addr_width-1:0]     dbg_reg,
    output logic [data_width-1:0]         rs,
    output logic [data_width-1:0]         rt,
    output logic [data_width-1:0]         dbg_data
);

    // Only the writable registers have storage
    logic [data_width-1:0] regs [0:reg_thread_count-1];

    // Registers 14 and 15 are formed from the lane's inputs
    function automatic logic [data_width-1:0] read_reg(input logic [reg_addr_width-1:0] addr);
        logic [data_width-1:0] value;
        if (addr == reg_addr_width'(reg_thread_count)) begin
            value = data_width'(thread_count);
        end else if (addr == reg_addr_width'(reg_thread_idx)) begin
            value = data_width'(thread_idx);
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    // Operand reads are combinational so the ALU sees them during EXECUTE
    assign rs = read_reg(rs_addr);
    assign rt = read_reg(rt_addr);
    assign dbg_data = read_reg(dbg_reg);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_thread_count; i++) begin
                regs[i] <= '0;
            end
        end else if (enable && core_state == UPDATE && reg_write_enable) begin
            // Writes aimed at 14 or 15 fall through and are lost
            if (rd < reg_addr_width'(reg_thread_count)) begin
                regs[rd] <= (reg_input_mux == reg_in_imm) ? immediate : alu_out;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/pc_nzp.sv */
// Program counter and NZP unit
`default_nettype none
`timescale 1ns/1ns

module pc_nzp import gpu_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  core_state_t         core_state,
    input  logic                pc_mux,
    input  logic [2:0]          nzp_mask,
    input  logic [pc_width-1:0] branch_target,
    input  logic                nzp_write_enable,
    input  logic [2:0]          alu_nzp,
    output logic [pc_width-1:0] pc
);

    // Flags in positive, zero, negative order from bit 2 down
    logic [2:0] nzp;
    logic       take_branch;

    // The test sees the flags held before this UPDATE edge
    assign take_branch = pc_mux && ((nzp_mask & nzp) != 3'b000);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            nzp <= 3'b000;
        end else if (core_state == IDLE || core_state == DONE) begin
            // Parked at zero so that a start always fetches from the first word
            pc <= '0;
        end else if (core_state == UPDATE) begin
            if (nzp_write_enable) begin
                nzp <= alu_nzp;
            end
            pc <= take_branch ? branch_target : pc + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/scheduler.sv */
// Core state machine
`default_nettype none
`timescale 1ns/1ns

module scheduler import gpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic        is_ret,
    output core_state_t core_state,
    output logic        done
);

    core_state_t next_state;

    // Each instruction walks the same four states without a stall
    always_comb begin
        next_state = core_state;
        case (core_state)
            IDLE: begin
                if (start) begin
                    next_state = FETCH;
                end
            end
            FETCH: next_state = DECODE;
            DECODE: next_state = EXECUTE;
            EXECUTE: next_state = UPDATE;
            UPDATE: begin
                // RET retires like any instruction and then halts the core
                if (is_ret) begin
                    next_state = DONE;
                end else begin
                    next_state = FETCH;
                end
            end
            DONE: begin
                // A new start reruns the program without a reset
                if (start) begin
                    next_state = FETCH;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            core_state <= IDLE;
        end else begin
            core_state <= next_state;
        end
    end

    // Done is high for as long as the core sits in DONE
    assign done = (core_state == DONE);

endmodule

`default_nettype wire

/* logic/compute_core.sv */
// SIMT compute core top level
`default_nettype none
`timescale 1ns/1ns

module compute_core import gpu_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          prog_we,
    input  logic [pc_width-1:0]           prog_addr,
    input  logic [instr_width-1:0]        prog_data,
    input  logic                          start,
    input  logic [thread_count_width-1:0] thread_count,
    input  logic [lane_idx_width-1:0]     dbg_thread,
    input  logic [reg_addr_width-1:0]     dbg_reg,
    output logic                          done,
    output logic [data_width-1:0]         dbg_data
);

    core_state_t core_state;

    // Program store and the fetched word
    logic [instr_width-1:0] prog_mem [0:prog_depth-1];
    logic [instr_width-1:0] instruction;
    logic [pc_width-1:0]    pc;

    // Thread count held for the whole run
    logic [thread_count_width-1:0] active_threads;
    logic                          host_window;

    // Decoded fields shared by every lane
    logic [reg_addr_width-1:0] rd;
    logic [reg_addr_width-1:0] rs_addr;
    logic [reg_addr_width-1:0] rt_addr;
    logic [data_width-1:0]     immediate;
    logic [2:0]                nzp_mask;
    logic [pc_width-1:0]       branch_target;
    logic                      reg_write_enable;
    logic                      reg_input_mux;
    logic [1:0]                alu_arith_mux;
    logic                      alu_output_mux;
    logic                      nzp_write_enable;
    logic                      pc_mux;
    logic                      is_ret;

    // Per-lane datapath
    logic [max_threads-1:0] lane_enable;
    logic [data_width-1:0]  lane_rs [max_threads];
    logic [data_width-1:0]  lane_rt [max_threads];
    logic [data_width-1:0]  lane_alu_out [max_threads];
    logic [data_width-1:0]  lane_dbg [max_threads];

    // The host may only touch the core while it is not running
    assign host_window = (core_state == IDLE) || (core_state == DONE);

    always_ff @(posedge clk) begin
        if (prog_we && host_window) begin
            prog_mem[prog_addr] <= prog_data;
        end
        if (core_state == FETCH) begin
            instruction <= prog_mem[pc];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_threads <= '0;
        end else if (start && host_window) begin
            active_threads <= thread_count;
        end
    end

    scheduler u_scheduler (
        .clk(clk), .reset(reset), .start(start), .is_ret(is_ret),
        .core_state(core_state), .done(done)
    );

    decoder u_decoder (
        .clk(clk), .reset(reset), .core_state(core_state), .instruction(instruction),
        .rd(rd), .rs_addr(rs_addr), .rt_addr(rt_addr), .immediate(immediate),
        .nzp_mask(nzp_mask), .branch_target(branch_target),
        .reg_write_enable(reg_write_enable), .reg_input_mux(reg_input_mux),
        .alu_arith_mux(alu_arith_mux), .alu_output_mux(alu_output_mux),
        .nzp_write_enable(nzp_write_enable), .pc_mux(pc_mux), .is_ret(is_ret)
    );

    // Lane 0 alone feeds the flags, so all threads branch together
    pc_nzp u_pc_nzp (
        .clk(clk), .reset(reset), .core_state(core_state), .pc_mux(pc_mux),
        .nzp_mask(nzp_mask), .branch_target(branch_target),
        .nzp_write_enable(nzp_write_enable), .alu_nzp(lane_alu_out[0][2:0]), .pc(pc)
    );

    for (genvar i = 0; i < max_threads; i++) begin : g_lane
        assign lane_enable[i] = (thread_count_width'(i) < active_threads);

        alu u_alu (
            .clk(clk), .reset(reset), .enable(lane_enable[i]), .core_state(core_state),
            .alu_arith_mux(alu_arith_mux), .alu_output_mux(alu_output_mux),
            .rs(lane_rs[i]), .rt(lane_rt[i]), .alu_out(lane_alu_out[i])
        );

        registers u_registers (
            .clk(clk), .reset(reset), .enable(lane_enable[i]), .core_state(core_state),
            .thread_count(active_threads), .thread_idx(lane_idx_width'(i)),
            .rs_addr(rs_addr), .rt_addr(rt_addr), .rd(rd),
            .reg_write_enable(reg_write_enable), .reg_input_mux(reg_input_mux),
            .immediate(immediate), .alu_out(lane_alu_out[i]), .dbg_reg(dbg_reg),
            .rs(lane_rs[i]), .rt(lane_rt[i]), .dbg_data(lane_dbg[i])
        );
    end

    // Read-back picks one lane and works in every state
    assign dbg_data = lane_dbg[dbg_thread];

endmodule

`default_nettype wire

/* tb/clock_gen.sv */
// Testbench clock and reset
`default_nettype none
`timescale 1ns/1ns

module clock_gen (
    output logic clk,
    output logic reset
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset is held for five rising edges and released just after the last one
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

/* tb/core_assert.sv */
// Scheduler assertions
`default_nettype none
`timescale 1ns/1ns

module core_assert import gpu_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        start,
    input core_state_t core_state,
    input logic        done
);

    // done is a pure decode of the DONE state
    assert property (@(posedge clk) disable iff (reset) done == (core_state == DONE))
        else $error("done does not match the DONE state");

    // A fetch is entered only from a retired instruction or from a start while halted
    property fetch_entry;
        @(posedge clk) disable iff (reset)
            (core_state == FETCH) |->
                ($past(core_state) == UPDATE) ||
                ($past(start) && ($past(core_state) == IDLE || $past(core_state) == DONE));
    endproperty

    assert property (fetch_entry)
        else $error("FETCH entered from an illegal state");

    // Codes 6 and 7 are not states
    assert property (@(posedge clk) disable iff (reset)
        core_state inside {IDLE, FETCH, DECODE, EXECUTE, UPDATE, DONE})
        else $error("core state outside the enum range");

endmodule

bind scheduler core_assert u_core_assert (
    .clk(clk), .reset(reset), .start(start), .core_state(core_state), .done(done)
);

`default_nettype wire

/* tb/core_tb.sv */
// SIMT core testbench
`default_nettype none
`timescale 1ns/1ns

module core_tb import gpu_pkg::*; ();

    // Case file is a flat list of four-word records
    localparam int max_records = 256;
    localparam int max_words = max_records * 4;

    logic                          clk;
    logic                          reset;
    logic                          prog_we;
    logic [pc_width-1:0]           prog_addr;
    logic [instr_width-1:0]        prog_data;
    logic                          start;
    logic [thread_count_width-1:0] thread_count;
    logic [lane_idx_width-1:0]     dbg_thread;
    logic [reg_addr_width-1:0]     dbg_reg;
    logic                          done;
    logic [data_width-1:0]         dbg_data;

    logic [15:0] case_words [0:max_words-1];
    logic [31:0] rng_state = 32'd25;
    int checks = 0;
    int reg_errors = 0;
    int state_errors = 0;
    int cycle_errors = 0;
    int other_errors = 0;
    int cycle_count = 0;
    int timeout_limit = 0;

    clock_gen u_clock_gen (.clk(clk), .reset(reset));

    compute_core UUT (
        .clk(clk), .reset(reset), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .start(start), .thread_count(thread_count),
        .dbg_thread(dbg_thread), .dbg_reg(dbg_reg), .done(done), .dbg_data(dbg_data)
    );

    // 32-bit xorshift step
    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Number of case-start records before the end marker
    function automatic int count_cases();
        int n;
        int rec;
        n = 0;
        rec = 0;
        while (rec < max_records && case_words[rec*4] != 16'h0000) begin
            if (case_words[rec*4] == 16'h0001) begin
                n++;
            end
            rec++;
        end
        return n;
    endfunction

    task automatic check_reg(input string name, input logic [data_width-1:0] got,
                             input logic [data_width-1:0] expected);
        checks++;
        if (got !== expected) begin
            reg_errors++;
            $display("Mismatch %s: got 0x%02h, expected 0x%02h", name, got, expected);
        end
    endtask

    task automatic check_state(input string name, input core_state_t got,
                               input core_state_t expected);
        checks++;
        if (got !== expected) begin
            state_errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int expected);
        checks++;
        if (got != expected) begin
            cycle_errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        checks++;
        if (got !== expected) begin
            state_errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    // One program word that is written on the edge after the drive
    task automatic write_program_word(input logic [pc_width-1:0] addr,
                                      input logic [instr_width-1:0] word);
        @(posedge clk);
        #1;
        prog_we = 1'b1;
        prog_addr = addr;
        prog_data = word;
        @(posedge clk);
        #1;
        prog_we = 1'b0;
    endtask

    // Start pulse and a count of edges until done with the drive edge as zero
    task automatic run_program(input logic [thread_count_width-1:0] count,
                               input int expected_instrs);
        int cycles;
        @(posedge clk);
        #1;
        thread_count = count;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        cycles = 1;
        check_state("core_state after start", UUT.core_state, FETCH);
        // The watchdog ends the run if done never comes
        while (!done) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        // Loops have no fixed length so their latency is not checked
        if (expected_instrs != 0) begin
            check_cycles("done latency", cycles, 4 * expected_instrs + 1);
        end
        check_state("core_state at done", UUT.core_state, DONE);
    endtask

    // Read-back port is combinational and is sampled well after the drive
    task automatic read_register(input logic [lane_idx_width-1:0] thread,
                                 input logic [reg_addr_width-1:0] index,
                                 input logic [data_width-1:0] expected);
        @(posedge clk);
        #1;
        dbg_thread = thread;
        dbg_reg = index;
        #10;
        check_reg($sformatf("dbg_data t%0d r%0d", thread, index), dbg_data, expected);
    endtask

    // Watchdog over the whole run
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout: the run went past its limit of %0d cycles", timeout_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        logic [15:0] kind;
        logic [15:0] arg_a;
        logic [15:0] arg_b;
        logic [15:0] arg_c;
        logic [thread_count_width-1:0] case_threads;
        logic [pc_width-1:0] load_addr;
        int rec;
        int num_cases;
        int gap;

        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        start = 1'b0;
        thread_count = '0;
        dbg_thread = '0;
        dbg_reg = '0;
        case_threads = '0;
        load_addr = '0;

        for (int i = 0; i < max_words; i++) begin
            case_words[i] = 16'h0000;
        end
        $readmemh("tb/core_cases.txt", case_words);
        num_cases = count_cases();
        timeout_limit = num_cases * (4 * prog_depth + 20);
        if (num_cases == 0) begin
            other_errors++;
            $display("The case file holds no cases");
        end

        // Idle state right after reset
        @(negedge reset);
        #1;
        check_flag("done after reset", done, 1'b0);
        check_state("core_state after reset", UUT.core_state, IDLE);

        rec = 0;
        while (rec < max_records && case_words[rec*4] != 16'h0000) begin
            kind = case_words[rec*4];
            arg_a = case_words[rec*4+1];
            arg_b = case_words[rec*4+2];
            arg_c = case_words[rec*4+3];
            case (kind)
                16'h0001: begin
                    // Random idle gap of 0 to 7 cycles ahead of each case
                    rng_state = xorshift32(rng_state);
                    gap = int'(rng_state[2:0]);
                    repeat (gap) @(posedge clk);
                    case_threads = arg_a[thread_count_width-1:0];
                    load_addr = '0;
                end
                16'h0002: begin
                    write_program_word(load_addr, arg_a);
                    load_addr = load_addr + 1'b1;
                end
                16'h0003: begin
                    read_register(arg_a[lane_idx_width-1:0], arg_b[reg_addr_width-1:0],
                                  arg_c[data_width-1:0]);
                end
                16'h0004: run_program(case_threads, int'(arg_a));
                default: begin
                    other_errors++;
                    $display("Unknown record kind %0h at record %0d", kind, rec);
                end
            endcase
            rec++;
        end

        repeat (2) @(posedge clk);
        $display("Checks %0d, register errors %0d, state errors %0d, cycle errors %0d, other %0d",
                 checks, reg_errors, state_errors, cycle_errors, other_errors);
        if (reg_errors + state_errors + cycle_errors + other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
logic/gpu_pkg.sv
logic/alu.sv
logic/decoder.sv
logic/registers.sv
logic/pc_nzp.sv
logic/scheduler.sv
logic/compute_core.sv
tb/clock_gen.sv
tb/core_assert.sv
tb/core_tb.sv

/* run.sh */
#!/bin/sh
# Build the SIMT core testbench with Verilator, run it, then judge the log
rm -f sim.log
verilator --binary --timing --assert --top-module core_tb -f list.f -o core_sim \
    && ./obj_dir/core_sim > sim.log 2>&1 \
    || echo "SOME TESTS FAILED" >> sim.log
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0

/* tb/core_cases.txt */
// Four hex words per line: kind, a, b, c
// Kind 1 starts a case with a threads, 2 loads program word a, 4 runs and expects a
// instructions (0 skips the count), 3 expects thread a register b to hold c, 0 ends
0001 0004 0000 0000
0002 900A 0000 0000
0002 310F 0000 0000
0002 42F0 0000 0000
0002 5311 0000 0000
0002 6431 0000 0000
0002 F000 0000 0000
0004 0006 0000 0000
0003 0000 0001 000A
0003 0000 0002 00F6
0003 0001 0002 00F7
0003 0002 0003 0090
0003 0003 0003 00A9
0003 0003 0004 000D
0001 0004 0000 0000
0002 9500 0000 0000
0002 9623 0000 0000
0002 6765 0000 0000
0002 5866 0000 0000
0002 9E55 0000 0000
0002 3F66 0000 0000
0002 F000 0000 0000
0004 0007 0000 0000
0003 0000 0007 00FF
0003 0003 0008 00C9
0003 0002 000E 0004
0003 0001 000F 0001
0003 0003 000F 0003
0001 0004 0000 0000
0002 9005 0000 0000
0002 9101 0000 0000
0002 9200 0000 0000
0002 9300 0000 0000
0002 3220 0000 0000
0002 322F 0000 0000
0002 4001 0000 0000
0002 2003 0000 0000
0002 1804 0000 0000
0002 F000 0000 0000
0004 0000 0000 0000
0003 0000 0000 0000
0003 0000 0002 000F
0003 0001 0002 0014
0003 0003 0002 001E
0001 0002 0000 0000
0002 9277 0000 0000
0002 34EF 0000 0000
0002 F000 0000 0000
0004 0003 0000 0000
0003 0000 0002 0077
0003 0001 0002 0077
0003 0002 0002 0019
0003 0003 0002 001E
0003 0001 0004 0003
0003 0002 0004 000C
0003 0000 000E 0002
0003 0003 000E 0002
0001 0001 0000 0000
0002 9942 0000 0000
0002 F000 0000 0000
0004 0002 0000 0000
0003 0000 0009 0042
0003 0001 0009 0000
0003 0002 000E 0001
0003 0003 000F 0003
0000 0000 0000 0000
